//--- rtl/bubble_geometry_pkg.sv
package bubble_geometry_pkg;

    // widths with a meaning of their own
    typedef logic [9:0]  phase_t;      // rotating field phase count
    typedef logic [11:0] position_t;   // absolute loop position
    typedef logic [12:0] cycle_num_t;  // serial bit number, boot or page

    // one bubble cycle at 48 MHz, four times the old ftg rate
    localparam int unsigned CLOCKS_PER_BUBBLE_CYCLE = 480;

    // field phase points
    localparam phase_t PHASE_REST     = 10'd0;    // field stopped
    localparam phase_t PHASE_FIRST_IN = 10'd88;   // first input sample
    localparam phase_t PHASE_MINUS_X  = 10'd208;  // half disk at -x, rotation may stop
    localparam phase_t PHASE_BOUT     = 10'd326;  // launch, 2 clks ahead of -y
    localparam phase_t PHASE_PLUS_Y   = 10'd568;  // half disk at +y, end of cycle

    // restart point after +y, keeps the cycle at 480 clks
    localparam phase_t PHASE_WRAP =
        phase_t'(PHASE_PLUS_Y - CLOCKS_PER_BUBBLE_CYCLE + 1);

    // empty propagation line
    localparam cycle_num_t CYCLE_NUM_NONE = '1;

endpackage

//--- rtl/access_mode_pkg.sv
package access_mode_pkg;

    // bit 2 field rotating, bit 1 data flows, bit 0 user area
    typedef enum logic [2:0] {
        RST  = 3'b000,
        STBY = 3'b001,
        BOOT = 3'b110,
        USER = 3'b111,
        IDLE = 3'b100,
        SWAP = 3'b101
    } access_mode_t;

    localparam int MODE_ROTATE_BIT = 2;
    localparam int MODE_DATA_BIT   = 1;
    localparam int MODE_USER_BIT   = 0;

    // {bss_n, booten_n, bsen_n, repen_n, swapen_n} after the synchronizer
    typedef logic [4:0] ctrl_code_t;

    localparam ctrl_code_t LOOP_RESET   = 5'b10111;  // power-up, or end of boot access
    localparam ctrl_code_t BOOT_STANDBY = 5'b00111;
    localparam ctrl_code_t BOOT_ACCESS  = 5'b10011;  // bootloops shifting out
    localparam ctrl_code_t PAGE_RESET   = 5'b11111;
    localparam ctrl_code_t PAGE_STANDBY = 5'b01111;
    localparam ctrl_code_t PAGE_SEEK    = 5'b11011;  // also held while a page loads
    localparam ctrl_code_t REPLICATE    = 5'b11001;
    localparam ctrl_code_t SWAP_PULSE   = 5'b11010;

endpackage

//--- rtl/bubble_ctrl_if.sv
`timescale 1ns/1ps

// synchronized bubble controller lines, all active low
interface bubble_ctrl_if;

    logic bss_n;     // shift start
    logic bsen_n;    // shift enable, field rotates while low
    logic repen_n;   // replicator, already masked by bootloop enable
    logic booten_n;  // bootloop enable
    logic swapen_n;  // swap gate

    modport source (
        output bss_n,
        output bsen_n,
        output repen_n,
        output booten_n,
        output swapen_n
    );

    modport sink (
        input bss_n,
        input bsen_n,
        input repen_n,
        input booten_n,
        input swapen_n
    );

endinterface

//--- rtl/ctrl_synchronizer.sv
`timescale 1ns/1ps

module ctrl_synchronizer
    import access_mode_pkg::*;
(
    input  logic          MCLK,
    input  logic          reset,
    input  logic          en_n,      // module enable
    input  logic          bss_n,
    input  logic          bsen_n,
    input  logic          repen_n,
    input  logic          booten_n,
    input  logic          swapen_n,
    bubble_ctrl_if.source ctrl
);

    localparam int SYNC_STAGES = 4;

    ctrl_code_t gated;                    // lines after enable gating
    ctrl_code_t sync_q [SYNC_STAGES];     // sync chain, oldest at the end

    // disabled module looks like loop reset
    // replicator pulse only counts with bootloop enable released
    always_comb
    begin
        gated = {en_n | bss_n,
                 ~en_n & booten_n,
                 en_n | bsen_n,
                 en_n | repen_n | ~booten_n,
                 en_n | swapen_n};
    end

    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            for (int i = 0; i < SYNC_STAGES; i++)
            begin
                sync_q[i] <= LOOP_RESET;  // idle pattern
            end
        end
        else
        begin
            sync_q[0] <= gated;
            for (int i = 1; i < SYNC_STAGES; i++)
            begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign {ctrl.bss_n, ctrl.booten_n, ctrl.bsen_n, ctrl.repen_n, ctrl.swapen_n} =
        sync_q[SYNC_STAGES-1];

endmodule

//--- rtl/access_mode_fsm.sv
`timescale 1ns/1ps

module access_mode_fsm
    import access_mode_pkg::*;
(
    input  logic         MCLK,
    input  logic         reset,
    bubble_ctrl_if.sink  ctrl,
    output access_mode_t mode
);

    ctrl_code_t   code;       // current line pattern
    access_mode_t mode_next;

    assign code = {ctrl.bss_n, ctrl.booten_n, ctrl.bsen_n, ctrl.repen_n, ctrl.swapen_n};

    always_comb
    begin
        mode_next = mode;  // unknown patterns hold
        case (code)
            LOOP_RESET, PAGE_RESET:
            begin
                if (mode != STBY)  // standby survives a reset pattern
                begin
                    mode_next = RST;
                end
            end
            BOOT_STANDBY, PAGE_STANDBY:
            begin
                if (mode == RST)
                begin
                    mode_next = STBY;
                end
            end
            BOOT_ACCESS:
            begin
                if (mode == STBY || mode == BOOT || mode == RST)
                begin
                    mode_next = BOOT;
                end
            end
            PAGE_SEEK:
            begin
                if (mode == STBY || mode == RST)
                begin
                    mode_next = IDLE;  // field on, nothing out yet
                end
            end
            REPLICATE:
            begin
                if (mode == IDLE)
                begin
                    mode_next = USER;  // page read starts
                end
            end
            SWAP_PULSE:
            begin
                if (mode == IDLE)
                begin
                    mode_next = SWAP;  // page write
                end
            end
            default:
            begin
                mode_next = mode;
            end
        endcase
    end

    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            mode <= RST;
        end
        else
        begin
            mode <= mode_next;
        end
    end

    a_mode_legal: assert property (@(posedge MCLK) disable iff (reset)
        mode inside {RST, STBY, BOOT, USER, IDLE, SWAP})
        else $error("access mode left the legal set");

endmodule

//--- rtl/field_phase_tracker.sv
`timescale 1ns/1ps

module field_phase_tracker
    import bubble_geometry_pkg::*, access_mode_pkg::*;
#(
    parameter int unsigned LOOP_POSITIONS = 2053,
    parameter int unsigned INIT_POSITION  = 1951
)
(
    input  logic         MCLK,
    input  logic         reset,
    input  access_mode_t mode,
    output phase_t       phase,
    output position_t    abs_position,
    output logic         bin_clk_en_n,   // input sample strobe
    output logic         bout_clk_en_n   // output launch strobe
);

    localparam position_t POS_LAST = position_t'(LOOP_POSITIONS - 1);

    logic rotating;

    assign rotating = mode[MODE_ROTATE_BIT];

    // rotating field model
    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            phase <= PHASE_REST;
        end
        else if (phase == PHASE_REST || phase == PHASE_MINUS_X)
        begin
            // start from rest, or stop at -x once rotation is released
            phase <= rotating ? phase + 1'b1 : PHASE_REST;
        end
        else if (phase == PHASE_PLUS_Y)
        begin
            phase <= PHASE_WRAP;  // next bubble cycle
        end
        else
        begin
            phase <= phase + 1'b1;
        end
    end

    // loop position, one step per bubble cycle
    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            abs_position <= position_t'(INIT_POSITION);
        end
        else if (phase == PHASE_PLUS_Y)
        begin
            abs_position <= (abs_position == POS_LAST) ? '0 : abs_position + 1'b1;
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            bin_clk_en_n  <= 1'b1;
            bout_clk_en_n <= 1'b1;
        end
        else
        begin
            bin_clk_en_n  <= !(phase == PHASE_FIRST_IN || phase == PHASE_PLUS_Y);
            bout_clk_en_n <= (phase != PHASE_BOUT);  // early for slow buffers
        end
    end

    a_phase_range: assert property (@(posedge MCLK) disable iff (reset)
        phase <= PHASE_PLUS_Y)
        else $error("field phase past +y");

    a_strobe_excl: assert property (@(posedge MCLK) disable iff (reset)
        !bin_clk_en_n |-> bout_clk_en_n)
        else $error("input and output strobes low together");

endmodule

//--- rtl/bubble_cycle_counter.sv
`timescale 1ns/1ps

module bubble_cycle_counter
    import bubble_geometry_pkg::*, access_mode_pkg::*;
#(
    parameter int unsigned PAGE_BITS      = 584,
    parameter int unsigned LOOP_POSITIONS = 2053,
    parameter int unsigned PROP_DELAY     = 98,
    parameter int unsigned INIT_POSITION  = 1951
)
(
    input  logic         MCLK,
    input  logic         reset,
    input  access_mode_t mode,
    input  phase_t       phase,
    output cycle_num_t   cycle_num
);

    localparam int unsigned DELAY_W = $clog2(PROP_DELAY + 1);
    localparam int unsigned PAGE_W  = $clog2(PAGE_BITS + 1);

    // two bootloops shift out back to back
    localparam cycle_num_t BOOT_LAST = cycle_num_t'(2 * LOOP_POSITIONS - 1);
    localparam cycle_num_t PAGE_LAST = cycle_num_t'(PAGE_BITS - 1);

    logic [DELAY_W-1:0] delay_cnt;   // cycles before first bit hits the detector
    logic [PAGE_W-1:0]  page_cnt;    // page bits launched so far
    cycle_num_t         boot_cnt;    // bootloop position, never pauses
    cycle_num_t         boot_next;
    logic               delay_done;

    assign boot_next  = (boot_cnt == BOOT_LAST) ? '0 : boot_cnt + 1'b1;
    assign delay_done = (delay_cnt == DELAY_W'(PROP_DELAY));

    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            cycle_num <= CYCLE_NUM_NONE;
            delay_cnt <= '0;
            page_cnt  <= '0;
            boot_cnt  <= cycle_num_t'(INIT_POSITION);
        end
        else if (phase == PHASE_REST)
        begin
            if (mode == RST)  // field stopped and reset, start over
            begin
                cycle_num <= CYCLE_NUM_NONE;
                delay_cnt <= '0;
                page_cnt  <= '0;
            end
        end
        else if (phase == PHASE_PLUS_Y)
        begin
            boot_cnt <= boot_next;
            if (!mode[MODE_DATA_BIT])
            begin
                // idle or swap, nothing goes out
                cycle_num <= CYCLE_NUM_NONE;
                delay_cnt <= '0;
                page_cnt  <= '0;
            end
            else if (!delay_done)
            begin
                cycle_num <= CYCLE_NUM_NONE;  // still propagating
                delay_cnt <= delay_cnt + 1'b1;
                page_cnt  <= '0;
            end
            else if (!mode[MODE_USER_BIT])
            begin
                cycle_num <= boot_next;  // boot output
                page_cnt  <= '0;
            end
            else if (page_cnt < PAGE_W'(PAGE_BITS))
            begin
                cycle_num <= cycle_num_t'(page_cnt);
                page_cnt  <= page_cnt + 1'b1;
            end
            else
            begin
                cycle_num <= PAGE_LAST;  // page done, hold last bit
            end
        end
    end

    // user cycle number comes from the page count, never past the page
    a_page_bound: assert property (@(posedge MCLK) disable iff (reset)
        (mode == USER && phase == PHASE_PLUS_Y)
        |=> (cycle_num == CYCLE_NUM_NONE || cycle_num < PAGE_BITS))
        else $error("user cycle number beyond page length");

endmodule

//--- rtl/timing_generator.sv
`timescale 1ns/1ps

module timing_generator
    import bubble_geometry_pkg::*, access_mode_pkg::*;
#(
    parameter int unsigned PAGE_BITS      = 584,   // bits per page
    parameter int unsigned LOOP_POSITIONS = 2053,  // bubbles per loop
    parameter int unsigned PROP_DELAY     = 98,    // cycles to the detector
    parameter int unsigned INIT_POSITION  = 1951   // below LOOP_POSITIONS
)
(
    input  logic       MCLK,          // 48 MHz
    input  logic       reset,
    input  logic       en_n,
    input  logic       bss_n,
    input  logic       bsen_n,
    input  logic       repen_n,
    input  logic       booten_n,
    input  logic       swapen_n,
    output logic [2:0] access_mode,
    output cycle_num_t cycle_num,
    output logic       bin_clk_en_n,
    output logic       bout_clk_en_n,
    output position_t  abs_position
);

    access_mode_t mode;
    phase_t       phase;

    bubble_ctrl_if ctrl_bus ();

    assign access_mode = mode;

    ctrl_synchronizer i_ctrl_synchronizer (
        .MCLK     (MCLK),
        .reset    (reset),
        .en_n     (en_n),
        .bss_n    (bss_n),
        .bsen_n   (bsen_n),
        .repen_n  (repen_n),
        .booten_n (booten_n),
        .swapen_n (swapen_n),
        .ctrl     (ctrl_bus.source)
    );

    access_mode_fsm i_access_mode_fsm (
        .MCLK  (MCLK),
        .reset (reset),
        .ctrl  (ctrl_bus.sink),
        .mode  (mode)
    );

    field_phase_tracker #(
        .LOOP_POSITIONS (LOOP_POSITIONS),
        .INIT_POSITION  (INIT_POSITION)
    ) i_field_phase_tracker (
        .MCLK          (MCLK),
        .reset         (reset),
        .mode          (mode),
        .phase         (phase),
        .abs_position  (abs_position),
        .bin_clk_en_n  (bin_clk_en_n),
        .bout_clk_en_n (bout_clk_en_n)
    );

    bubble_cycle_counter #(
        .PAGE_BITS      (PAGE_BITS),
        .LOOP_POSITIONS (LOOP_POSITIONS),
        .PROP_DELAY     (PROP_DELAY),
        .INIT_POSITION  (INIT_POSITION)
    ) i_bubble_cycle_counter (
        .MCLK      (MCLK),
        .reset     (reset),
        .mode      (mode),
        .phase     (phase),
        .cycle_num (cycle_num)
    );

endmodule

//--- tests/tb_timing_generator.sv
`timescale 1ns/1ps

module tb_timing_generator
    import bubble_geometry_pkg::*, access_mode_pkg::*;
();

    // shrunk loop geometry
    localparam int unsigned PAGE_BITS      = 20;
    localparam int unsigned LOOP_POSITIONS = 61;
    localparam int unsigned PROP_DELAY     = 6;
    localparam int unsigned INIT_POSITION  = 40;
    localparam int unsigned CYCLE_CLKS     = 480;  // input strobe period
    localparam int unsigned BOUT_LAG       = 238;  // input strobe to output strobe
    localparam int unsigned MODE_LAG       = 5;    // line change to mode
    localparam int unsigned QUIET_CLKS     = 300;  // longer than any strobe gap

    // {en_n, bss_n, bsen_n, repen_n, booten_n, swapen_n}
    localparam logic [5:0] DISABLED     = 6'b111111;
    localparam logic [5:0] BOOT_STBY    = 6'b001101;
    localparam logic [5:0] BOOT_ACC     = 6'b010101;
    localparam logic [5:0] LOOP_RST     = 6'b011101;
    localparam logic [5:0] PAGE_STBY    = 6'b001111;
    localparam logic [5:0] PAGE_SEEK_IN = 6'b010111;
    localparam logic [5:0] REPL_PULSE   = 6'b010011;  // booten_n high, so it counts
    localparam logic [5:0] SWAP_IN      = 6'b010110;
    localparam logic [5:0] PAGE_RST     = 6'b011111;

    logic         MCLK;
    logic         reset;
    logic         en_n;
    logic         bss_n;
    logic         bsen_n;
    logic         repen_n;
    logic         booten_n;
    logic         swapen_n;
    logic [2:0]   access_mode;
    cycle_num_t   cycle_num;
    logic         bin_clk_en_n;
    logic         bout_clk_en_n;
    position_t    abs_position;

    logic [15:0]  lfsr;            // stimulus noise
    logic         disabled_phase;  // en_n high since reset
    access_mode_t mode_d;          // mode the dut used on the previous edge
    logic         saw_bout;        // output strobe since last input strobe
    logic         end_strobe;      // input strobe that closes a bubble cycle
    int unsigned  since_bin;
    int unsigned  since_drive;     // clocks since any input moved
    logic [5:0]   in_prev;
    position_t    m_pos;
    cycle_num_t   m_boot;          // bootloop count, 0 .. 121
    int unsigned  m_delay;         // data cycles in the propagation line
    int unsigned  m_page;          // page bits out so far
    cycle_num_t   exp_cycle;       // cycle number due at the next end strobe

    timing_generator #(
        .PAGE_BITS      (PAGE_BITS),
        .LOOP_POSITIONS (LOOP_POSITIONS),
        .PROP_DELAY     (PROP_DELAY),
        .INIT_POSITION  (INIT_POSITION)
    ) i_timing_generator (
        .MCLK          (MCLK),
        .reset         (reset),
        .en_n          (en_n),
        .bss_n         (bss_n),
        .bsen_n        (bsen_n),
        .repen_n       (repen_n),
        .booten_n      (booten_n),
        .swapen_n      (swapen_n),
        .access_mode   (access_mode),
        .cycle_num     (cycle_num),
        .bin_clk_en_n  (bin_clk_en_n),
        .bout_clk_en_n (bout_clk_en_n),
        .abs_position  (abs_position)
    );

    always #50 MCLK = ~MCLK;  // 100 ns period

    // first strobe after a start has no output strobe ahead of it
    assign end_strobe = !bin_clk_en_n && saw_bout;

    always_comb
    begin
        if (!(mode_d inside {BOOT, USER}) || m_delay < PROP_DELAY)
            exp_cycle = CYCLE_NUM_NONE;  // no data, or bits not at the detector yet
        else if (mode_d == BOOT)
            exp_cycle = cycle_num_t'((m_boot + 1) % (2 * LOOP_POSITIONS));
        else if (m_page < PAGE_BITS)
            exp_cycle = cycle_num_t'(m_page);
        else
            exp_cycle = cycle_num_t'(PAGE_BITS - 1);  // page over
    end

    always @(posedge MCLK)
    begin
        in_prev <= {en_n, bss_n, bsen_n, repen_n, booten_n, swapen_n};
        if (reset)
        begin
            mode_d      <= RST;
            saw_bout    <= 1'b0;
            since_bin   <= 0;
            since_drive <= 0;
            m_pos       <= position_t'(INIT_POSITION);
            m_boot      <= cycle_num_t'(INIT_POSITION);
            m_delay     <= 0;
            m_page      <= 0;
        end
        else
        begin
            since_drive <= (in_prev != {en_n, bss_n, bsen_n, repen_n, booten_n, swapen_n})
                           ? 0 : since_drive + 1;
            mode_d      <= access_mode_t'(access_mode);
            saw_bout    <= bin_clk_en_n && (saw_bout || !bout_clk_en_n);
            since_bin   <= bin_clk_en_n ? since_bin + 1 : 1;
            if (end_strobe)
            begin
                m_pos  <= position_t'((m_pos + 1) % LOOP_POSITIONS);
                m_boot <= cycle_num_t'((m_boot + 1) % (2 * LOOP_POSITIONS));  // never pauses
            end
            if (end_strobe && mode_d inside {BOOT, USER})
            begin
                m_delay <= (m_delay < PROP_DELAY) ? m_delay + 1 : m_delay;
                m_page  <= (m_delay < PROP_DELAY || mode_d == BOOT) ? 0 : m_page + 1;
            end
            else if (end_strobe || mode_d == RST)
            begin
                m_delay <= 0;  // line empties
                m_page  <= 0;
            end
        end
    end

    a_disabled: assert property (@(posedge MCLK) disable iff (reset)
        disabled_phase |-> access_mode == RST && bin_clk_en_n && bout_clk_en_n
            && cycle_num == CYCLE_NUM_NONE && abs_position == position_t'(INIT_POSITION))
        else value_error("outputs not idle while disabled");
    a_bin_width: assert property (@(posedge MCLK) disable iff (reset)
        !bin_clk_en_n |=> bin_clk_en_n)
        else value_error("input strobe longer than one clock");
    a_bout_width: assert property (@(posedge MCLK) disable iff (reset)
        !bout_clk_en_n |=> bout_clk_en_n)
        else value_error("output strobe longer than one clock");
    a_bin_period: assert property (@(posedge MCLK) disable iff (reset)
        end_strobe |-> since_bin == CYCLE_CLKS)
        else value_error("input strobe period wrong");
    a_bout_lag: assert property (@(posedge MCLK) disable iff (reset)
        !bout_clk_en_n |-> since_bin == BOUT_LAG)
        else value_error("output strobe offset wrong");
    a_position: assert property (@(posedge MCLK) disable iff (reset)
        abs_position == position_t'(end_strobe ? (m_pos + 1) % LOOP_POSITIONS : m_pos))
        else value_error("abs_position off the model");
    a_cycle_num: assert property (@(posedge MCLK) disable iff (reset)
        end_strobe |-> cycle_num == exp_cycle)
        else value_error("cycle_num off the model");
    a_cycle_hold: assert property (@(posedge MCLK) disable iff (reset)
        !end_strobe && mode_d != RST |-> $stable(cycle_num))
        else value_error("cycle_num moved between cycles");
    a_mode_lag: assert property (@(posedge MCLK) disable iff (reset)
        $changed(access_mode) |-> since_drive <= MODE_LAG)
        else value_error("mode changed without a line change");

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_error(input string msg);
        stop_on_error($sformatf("FAIL %0t: %s", $time, msg));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drive_lines(input logic [5:0] v);
        @(posedge MCLK);
        {en_n, bss_n, bsen_n, repen_n, booten_n, swapen_n} <= v;
    endtask

    task automatic enter_mode(input logic [5:0] v, input access_mode_t m);
        int unsigned clks;
        clks = 0;
        drive_lines(v);
        while (access_mode != m && clks <= MODE_LAG)
        begin
            @(negedge MCLK);
            if (access_mode != m)
                clks++;
        end
        if (access_mode != m)
            stop_on_error($sformatf("mode %s not reached within %0d clocks at %0t",
                                    m.name(), MODE_LAG, $time));
    endtask

    task automatic run_cycles(input int unsigned n);
        int unsigned seen;
        int unsigned clks;
        seen = 0;
        clks = 0;
        while (seen < n && clks < (n + 1) * CYCLE_CLKS)
        begin
            @(negedge MCLK);
            clks++;
            if (!bin_clk_en_n)
                seen++;
        end
        if (seen < n)
            stop_on_error($sformatf("input strobes stopped at %0t", $time));
    endtask

    task automatic wait_field_stop();
        int unsigned quiet;
        int unsigned clks;
        quiet = 0;
        clks  = 0;
        while (quiet < QUIET_CLKS && clks < 4 * CYCLE_CLKS)
        begin
            @(negedge MCLK);
            clks++;
            quiet = (bin_clk_en_n && bout_clk_en_n) ? quiet + 1 : 0;
        end
        if (quiet < QUIET_CLKS)
            stop_on_error($sformatf("field still rotating at %0t", $time));
    endtask

    initial
    begin
        logic [4:0] rnd;
        MCLK           = 1'b0;
        reset          = 1'b1;
        {en_n, bss_n, bsen_n, repen_n, booten_n, swapen_n} = DISABLED;
        disabled_phase = 1'b0;
        lfsr           = 16'd21725;
        repeat (2) @(posedge MCLK);
        reset          <= 1'b0;
        disabled_phase <= 1'b1;
        repeat (40)  // line noise, module disabled
        begin
            for (int b = 0; b < 5; b++)
            begin
                lfsr   = lfsr_next(lfsr);
                rnd[b] = lfsr[0];
            end
            drive_lines({1'b1, rnd});
        end
        drive_lines(DISABLED);
        disabled_phase <= 1'b0;
        enter_mode(BOOT_STBY, STBY);
        enter_mode(BOOT_ACC, BOOT);
        run_cycles(90);  // past position and bootloop wrap
        enter_mode(LOOP_RST, RST);
        wait_field_stop();
        enter_mode(PAGE_STBY, STBY);
        enter_mode(PAGE_SEEK_IN, IDLE);
        run_cycles(3);
        enter_mode(REPL_PULSE, USER);
        drive_lines(PAGE_SEEK_IN);  // pulse over, user holds
        run_cycles(32);
        enter_mode(PAGE_RST, RST);
        wait_field_stop();
        enter_mode(PAGE_STBY, STBY);
        enter_mode(PAGE_SEEK_IN, IDLE);
        run_cycles(2);
        enter_mode(SWAP_IN, SWAP);
        drive_lines(PAGE_SEEK_IN);
        run_cycles(4);
        enter_mode(PAGE_RST, RST);
        wait_field_stop();
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- timing_generator.f
rtl/bubble_geometry_pkg.sv
rtl/access_mode_pkg.sv
rtl/bubble_ctrl_if.sv
rtl/ctrl_synchronizer.sv
rtl/access_mode_fsm.sv
rtl/field_phase_tracker.sv
rtl/bubble_cycle_counter.sv
rtl/timing_generator.sv
tests/tb_timing_generator.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_timing_generator \
		-f timing_generator.f -o Vtb_timing_generator
	./obj_dir/Vtb_timing_generator | \
		awk '{ print } /Test completed successfully/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
